//--- l1_cache_pkg.sv
//##############################
// geometry is fixed, direct mapped, 2 words per block
// frame layout {valid, dirty, tag, data}, data word 0 in the low bits
// addresses at or above NONCACHE_START bypass the cache
//##############################

package l1_cache_pkg;

    // processor word and block geometry
    localparam int WORD_W      = 32;
    localparam int BE_W        = WORD_W / 8;             // byte enables per word
    localparam int BLOCK_WORDS = 2;
    localparam int BLOCK_W     = WORD_W * BLOCK_WORDS;   // 64

    // 64 sets of one block each, 512 bytes of data
    localparam int N_SETS   = 64;
    localparam int SET_BITS = 6;
    localparam int OFS_BITS = 1;
    localparam int TAG_BITS = WORD_W - SET_BITS - OFS_BITS - 2;   // 23

    // frame bit positions
    localparam int FRAME_W = 2 + TAG_BITS + BLOCK_W;   // 89
    localparam int V_POS   = FRAME_W - 1;
    localparam int D_POS   = FRAME_W - 2;
    localparam int TAG_LSB = BLOCK_W;

    localparam logic [WORD_W-1:0] NONCACHE_START = 32'hF000_0000;

    // controller states
    localparam logic [2:0] S_CLEAR     = 3'd0;   // reset sweep
    localparam logic [2:0] S_LOOKUP    = 3'd1;
    localparam logic [2:0] S_FETCH     = 3'd2;
    localparam logic [2:0] S_WRITEBACK = 3'd3;
    localparam logic [2:0] S_FLUSH     = 3'd4;   // flush sweep

    // one address word, seen either as the bus value or as cache fields
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0] tag;
            logic [SET_BITS-1:0] set;
            logic [OFS_BITS-1:0] ofs;
            logic [1:0]          byte_bits;   // always ignored by the cache
        } f;
    } cache_addr_u;

endpackage

//--- cache_data_array.sv
//##############################
// no reset, the controller clears every set after reset
// read is combinational, write on the clock edge
//##############################

`timescale 1ns/1ns

module cache_data_array import l1_cache_pkg::*; (
    input  logic                CLK,
    input  logic [SET_BITS-1:0] sel,
    input  logic                wen,
    input  logic [FRAME_W-1:0]  wdata,
    input  logic [FRAME_W-1:0]  wmask,   // 1 keeps the stored bit
    output logic [FRAME_W-1:0]  rdata
);

    logic [FRAME_W-1:0] frames [N_SETS];

    assign rdata = frames[sel];

    // merge new bits over the old frame where the mask is clear
    always_ff @(posedge CLK) begin
        if (wen) begin
            frames[sel] <= (frames[sel] & wmask) | (wdata & ~wmask);
        end
    end

    // an X select would smear the write over unknown sets
    a_sel_known: assert property (@(posedge CLK) wen |-> !$isunknown(sel))
        else $error("frame write with unknown set select");

endmodule

//--- cache_lookup.sv
//##############################
// purely combinational
// frame must be the array output for the set of proc_addr
// victim_addr has zero offset and byte bits
//##############################

`timescale 1ns/1ns

module cache_lookup import l1_cache_pkg::*; (
    input  logic [WORD_W-1:0]  proc_addr,
    input  logic [BE_W-1:0]    proc_byte_en,
    input  logic [FRAME_W-1:0] frame,
    output logic               hit,
    output logic               pass_through,
    output logic [WORD_W-1:0]  hit_word,
    output logic               victim_dirty,
    output logic [WORD_W-1:0]  victim_addr,
    output logic [WORD_W-1:0]  byte_keep
);

    cache_addr_u         req;
    cache_addr_u         vic;
    logic [TAG_BITS-1:0] stored_tag;

    assign req.raw    = proc_addr;
    assign stored_tag = frame[TAG_LSB +: TAG_BITS];

    assign pass_through = proc_addr >= NONCACHE_START;
    assign hit = frame[V_POS] && (stored_tag == req.f.tag) && !pass_through;

    // word select within the block
    assign hit_word = frame[req.f.ofs*WORD_W +: WORD_W];

    // victim block lives at the stored tag in the same set
    always_comb begin
        vic.raw         = '0;
        vic.f.tag       = stored_tag;
        vic.f.set       = req.f.set;
    end

    assign victim_dirty = frame[V_POS] & frame[D_POS];
    assign victim_addr  = vic.raw;

    // one keep bit per data bit, set where the byte is not written
    always_comb begin
        for (int i = 0; i < BE_W; i++) begin
            byte_keep[i*8 +: 8] = {8{~proc_byte_en[i]}};
        end
    end

endmodule

//--- cache_sweep.sv
//##############################
// counter rests at set 0 between sweeps
// a flush pulse is held until the controller takes it
//##############################

`timescale 1ns/1ns

module cache_sweep import l1_cache_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    input  logic                step,
    input  logic                flush_taken,
    output logic [SET_BITS-1:0] sweep_set,
    output logic                sweep_last,
    output logic                flush_pending
);

    assign sweep_last = (sweep_set == SET_BITS'(N_SETS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sweep_set <= '0;
        end else if (step) begin
            sweep_set <= sweep_last ? '0 : sweep_set + 1'b1;   // wrap after last set
        end
    end

    // a new pulse wins over a take in the same cycle, so it is not dropped
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flush_pending <= 1'b0;
        end else if (flush) begin
            flush_pending <= 1'b1;
        end else if (flush_taken) begin
            flush_pending <= 1'b0;
        end
    end

    // a flush is only taken from lookup, never while a sweep is stepping
    a_step_vs_take: assert property (
        @(posedge CLK) disable iff (!nRST) !(step && flush_taken))
        else $error("sweep step and flush take in the same cycle");

endmodule

//--- cache_ctrl.sv
//##############################
// processor holds its request until proc_busy is low
// flush waits for lookup, so a miss in progress finishes first
// mem_busy high holds state and all memory outputs
//##############################

`timescale 1ns/1ns

module cache_ctrl import l1_cache_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  logic [WORD_W-1:0]   proc_addr,
    input  logic [WORD_W-1:0]   proc_wdata,
    input  logic [BE_W-1:0]     proc_byte_en,
    output logic [WORD_W-1:0]   proc_rdata,
    output logic                proc_busy,
    output logic                mem_ren,
    output logic                mem_wen,
    output logic [WORD_W-1:0]   mem_addr,
    output logic [BLOCK_W-1:0]  mem_wdata,
    output logic [BE_W-1:0]     mem_byte_en,
    input  logic [BLOCK_W-1:0]  mem_rdata,
    input  logic                mem_busy,
    input  logic                hit,
    input  logic                pass_through,
    input  logic [WORD_W-1:0]   hit_word,
    input  logic                victim_dirty,
    input  logic [WORD_W-1:0]   victim_addr,
    input  logic [WORD_W-1:0]   byte_keep,
    input  logic [FRAME_W-1:0]  frame,
    output logic [SET_BITS-1:0] arr_sel,
    output logic                arr_wen,
    output logic [FRAME_W-1:0]  arr_wdata,
    output logic [FRAME_W-1:0]  arr_wmask,
    input  logic [SET_BITS-1:0] sweep_set,
    input  logic                sweep_last,
    input  logic                flush_pending,
    output logic                step,
    output logic                flush_taken,
    output logic                flush_done
);

    logic [2:0]          state;
    logic [2:0]          next_state;
    cache_addr_u         req;
    cache_addr_u         line_addr;    // block aligned request
    cache_addr_u         flush_addr;   // victim block of the swept set
    logic [OFS_BITS-1:0] ofs;
    logic                block_xfer;

    always_comb begin
        req.raw               = proc_addr;
        line_addr             = req;
        line_addr.f.ofs       = '0;
        line_addr.f.byte_bits = '0;
        flush_addr.raw        = victim_addr;
        flush_addr.f.set      = sweep_set;   // lookup rebuilt it with the request set
    end

    assign ofs = req.f.ofs;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= S_CLEAR;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        proc_busy   = 1'b1;
        proc_rdata  = '0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_byte_en = '1;          // whole word lanes for block moves
        arr_sel     = req.f.set;
        arr_wen     = 1'b0;
        arr_wdata   = '0;
        arr_wmask   = '1;
        step        = 1'b0;
        flush_taken = 1'b0;
        flush_done  = 1'b0;

        case (state)
            S_CLEAR: begin
                arr_sel   = sweep_set;
                arr_wen   = 1'b1;
                arr_wmask = '0;    // whole frame to zero
                step      = 1'b1;
                if (sweep_last) begin
                    flush_done = 1'b1;
                    next_state = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (flush_pending) begin
                    flush_taken = 1'b1;
                    next_state  = S_FLUSH;
                end else if (proc_ren || proc_wen) begin
                    if (pass_through) begin
                        // single word in lane 0, disabled bytes zero
                        mem_ren     = proc_ren;
                        mem_wen     = proc_wen;
                        mem_addr    = proc_addr;
                        mem_byte_en = proc_byte_en;
                        mem_wdata   = {{(BLOCK_W-WORD_W){1'b0}}, proc_wdata & ~byte_keep};
                        proc_busy   = mem_busy;
                        proc_rdata  = mem_rdata[WORD_W-1:0];
                    end else if (hit) begin
                        proc_busy  = 1'b0;
                        proc_rdata = hit_word;
                        if (proc_wen) begin
                            arr_wen                          = 1'b1;
                            arr_wdata[ofs*WORD_W +: WORD_W]  = proc_wdata;
                            arr_wmask[ofs*WORD_W +: WORD_W]  = byte_keep;
                            arr_wdata[D_POS]                 = 1'b1;
                            arr_wmask[D_POS]                 = 1'b0;
                        end
                    end else begin
                        next_state = victim_dirty ? S_WRITEBACK : S_FETCH;
                    end
                end
            end
            S_FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = line_addr.raw;
                if (!mem_busy) begin
                    // fresh clean frame with the request tag
                    arr_wen    = 1'b1;
                    arr_wmask  = '0;
                    arr_wdata  = {1'b1, 1'b0, req.f.tag, mem_rdata};
                    next_state = S_LOOKUP;
                end
            end
            S_WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = victim_addr;
                mem_wdata = frame[BLOCK_W-1:0];
                if (!mem_busy) begin
                    arr_wen          = 1'b1;   // drop valid and dirty
                    arr_wmask[V_POS] = 1'b0;
                    arr_wmask[D_POS] = 1'b0;
                    next_state       = S_FETCH;
                end
            end
            S_FLUSH: begin
                arr_sel = sweep_set;
                if (victim_dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = flush_addr.raw;
                    mem_wdata = frame[BLOCK_W-1:0];
                end
                // clean sets go in one cycle, dirty ones wait for memory
                if (!victim_dirty || !mem_busy) begin
                    arr_wen   = 1'b1;
                    arr_wmask = '0;
                    step      = 1'b1;
                    if (sweep_last) begin
                        flush_done = 1'b1;
                        next_state = S_LOOKUP;
                    end
                end
            end
            default: next_state = S_CLEAR;
        endcase
    end

    // everything outside lookup moves whole blocks
    assign block_xfer = (state != S_LOOKUP) && (mem_ren || mem_wen);

    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
        else $error("memory read and write requested together");

    a_block_aligned: assert property (
        @(posedge CLK) disable iff (!nRST) block_xfer |-> mem_addr[OFS_BITS+1:0] == '0)
        else $error("block transfer on an unaligned address");

endmodule

//--- l1_cache.sv
//##############################
// direct mapped write-back L1 data cache
// busy for N_SETS cycles after reset while sets are cleared
// no coherence and no reservations
//##############################

`timescale 1ns/1ns

module l1_cache import l1_cache_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               proc_ren,
    input  logic               proc_wen,
    input  logic [WORD_W-1:0]  proc_addr,
    input  logic [WORD_W-1:0]  proc_wdata,
    input  logic [BE_W-1:0]    proc_byte_en,
    input  logic               flush,
    output logic [WORD_W-1:0]  proc_rdata,
    output logic               proc_busy,
    output logic               flush_done,
    output logic               mem_ren,
    output logic               mem_wen,
    output logic [WORD_W-1:0]  mem_addr,
    output logic [BLOCK_W-1:0] mem_wdata,
    output logic [BE_W-1:0]    mem_byte_en,
    input  logic [BLOCK_W-1:0] mem_rdata,
    input  logic               mem_busy
);

    logic                hit;
    logic                pass_through;
    logic [WORD_W-1:0]   hit_word;
    logic                victim_dirty;
    logic [WORD_W-1:0]   victim_addr;
    logic [WORD_W-1:0]   byte_keep;
    logic [FRAME_W-1:0]  frame;
    logic [SET_BITS-1:0] arr_sel;
    logic                arr_wen;
    logic [FRAME_W-1:0]  arr_wdata;
    logic [FRAME_W-1:0]  arr_wmask;
    logic [SET_BITS-1:0] sweep_set;
    logic                sweep_last;
    logic                flush_pending;
    logic                step;
    logic                flush_taken;

    cache_ctrl u_ctrl (.*);   // every port matches a local or top port by name

    cache_lookup u_lookup (
        .proc_addr    (proc_addr),
        .proc_byte_en (proc_byte_en),
        .frame        (frame),
        .hit          (hit),
        .pass_through (pass_through),
        .hit_word     (hit_word),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .byte_keep    (byte_keep)
    );

    cache_data_array u_array (
        .CLK   (CLK),
        .sel   (arr_sel),
        .wen   (arr_wen),
        .wdata (arr_wdata),
        .wmask (arr_wmask),
        .rdata (frame)
    );

    cache_sweep u_sweep (
        .CLK           (CLK),
        .nRST          (nRST),
        .flush         (flush),
        .step          (step),
        .flush_taken   (flush_taken),
        .sweep_set     (sweep_set),
        .sweep_last    (sweep_last),
        .flush_pending (flush_pending)
    );

endmodule

//--- tb_mem_model.sv
//##############################
// behavioral block memory, blocks of two words
// unwritten words read a pattern of their address
// busy is random, high about one cycle in three
//##############################

`timescale 1ns/1ns

module tb_mem_model #(
    parameter logic [31:0] NC_START = 32'hF000_0000
) (
    input  logic        CLK,
    input  logic        mem_ren,
    input  logic        mem_wen,
    input  logic [31:0] mem_addr,
    input  logic [63:0] mem_wdata,
    input  logic [3:0]  mem_byte_en,
    output logic [63:0] mem_rdata,
    output logic        mem_busy
);

    logic [63:0] blocks [logic [28:0]];   // keyed by block address
    logic [63:0] merged;
    int          stores = 0;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic logic [63:0] peek_block(input logic [31:0] a);
        logic [31:0] base;
        base = {a[31:3], 3'b000};
        if (blocks.exists(a[31:3])) begin
            return blocks[a[31:3]];
        end
        return {fill_word(base + 32'd4), fill_word(base)};
    endfunction

    function automatic logic [31:0] peek_word(input logic [31:0] a);
        logic [63:0] b;
        b = peek_block(a);
        return a[2] ? b[63:32] : b[31:0];
    endfunction

    initial begin
        mem_busy = 1'b1;
        forever begin
            @(posedge CLK);
            #1;
            mem_busy = ($urandom % 3) == 0;
        end
    end

    // uncached reads return the single word in lane 0
    always @(mem_ren, mem_addr, stores) begin
        if (!mem_ren) begin
            mem_rdata = '0;
        end else if (mem_addr >= NC_START) begin
            mem_rdata = {32'h0, peek_word(mem_addr)};
        end else begin
            mem_rdata = peek_block(mem_addr);
        end
    end

    // request is stable from here to the completing edge
    always @(negedge CLK) begin
        if (mem_wen && !mem_busy) begin
            if (mem_addr >= NC_START) begin
                merged = peek_block(mem_addr);
                for (int i = 0; i < 4; i++) begin
                    if (mem_byte_en[i]) begin
                        merged[mem_addr[2]*32 + i*8 +: 8] = mem_wdata[i*8 +: 8];
                    end
                end
            end else begin
                merged = mem_wdata;   // whole block
            end
            blocks[mem_addr[31:3]] = merged;
            stores++;
        end
    end

endmodule

//--- tb_l1_cache.sv
//##############################
// random traffic from seed 76 against a shadow word memory
// cacheable pool is three sets with four tags each
// expects 64 sets, 2 words per block, uncached from F000_0000
//##############################

`timescale 1ns/1ns

module tb_l1_cache;

    localparam int          N_SETS   = 64;
    localparam int          N_OPS    = 600;
    localparam int          TIMEOUT  = 3000;   // cycles allowed per wait
    localparam logic [31:0] NC_START = 32'hF000_0000;
    localparam time         DRV      = 2;      // input delay after the edge

    logic        CLK;
    logic        nRST;
    logic        proc_ren;
    logic        proc_wen;
    logic [31:0] proc_addr;
    logic [31:0] proc_wdata;
    logic [3:0]  proc_byte_en;
    logic        flush;
    logic [31:0] proc_rdata;
    logic        proc_busy;
    logic        flush_done;
    logic        mem_ren;
    logic        mem_wen;
    logic [31:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [3:0]  mem_byte_en;
    logic [63:0] mem_rdata;
    logic        mem_busy;

    int          seed   = 76;
    int          errors = 0;
    int          checks = 0;
    bit          hung   = 1'b0;            // a request never completed
    logic [31:0] shadow [logic [31:0]];    // cacheable words written so far
    bit          touched [logic [28:0]];   // blocks used since the last flush
    bit          fetched [logic [28:0]];   // blocks read from memory since then

    l1_cache u_dut (.*);

    tb_mem_model #(.NC_START(NC_START)) u_mem (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] byte_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return u_mem.fill_word(a);   // never written, still the fill pattern
    endfunction

    // four tags in each of sets 3, 22 and 41
    function automatic logic [31:0] pick_addr();
        logic [31:0] a;
        a       = '0;
        a[10:9] = 2'($urandom % 4);
        a[8:3]  = 6'(3 + 19 * ($urandom % 3));
        a[2]    = 1'($urandom % 2);
        return a;
    endfunction

    task automatic compare_hex(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_run();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge CLK);
        #DRV;
        flush = 1'b0;
    endtask

    // block writes must carry the newest data of the block
    always @(negedge CLK) begin
        if (nRST && !mem_busy && mem_addr < NC_START) begin
            if (mem_wen) begin
                compare_hex("mem_wdata", mem_wdata,
                            {shadow_word(mem_addr + 32'd4), shadow_word(mem_addr)});
                compare_hex("mem_byte_en", mem_byte_en, 4'hF);
            end
            if (mem_ren) begin
                fetched[mem_addr[31:3]] = 1'b1;
            end
        end
        if (nRST && flush_done) begin
            touched.delete();   // every set is invalid now
            fetched.delete();
        end
    end

    // one processor request held until proc_busy is low
    task automatic access(input bit wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] be);
        int          n;
        bit          nc;
        bit          cold;
        logic [31:0] lane;
        nc           = a >= NC_START;
        cold         = !nc && !touched.exists(a[31:3]);   // block cannot be cached
        lane         = d & byte_mask(be);
        proc_ren     = !wr;
        proc_wen     = wr;
        proc_addr    = a;
        proc_wdata   = d;
        proc_byte_en = be;
        n = 0;
        @(negedge CLK);
        while (proc_busy && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (proc_busy) begin
            $display("timeout waiting for the request at %h to complete", a);
            errors++;
            hung = 1'b1;
        end else begin
            if (nc) begin
                compare_hex("mem_addr", mem_addr, a);
                compare_hex("mem_byte_en", mem_byte_en, be);
                compare_hex("mem_wen", mem_wen, wr);
                compare_hex("mem_ren", mem_ren, !wr);
                if (wr) begin
                    compare_hex("mem_wdata", mem_wdata, {32'h0, lane});
                end else begin
                    compare_hex("proc_rdata", proc_rdata, u_mem.peek_word(a));
                end
            end else if (!wr) begin
                compare_hex("proc_rdata", proc_rdata, shadow_word(a));
            end
            if (cold) begin
                checks++;
                if (!fetched.exists(a[31:3])) begin
                    $display("no memory fetch seen for the block at %h", a);
                    errors++;
                end
            end
            @(posedge CLK);
            if (wr && !nc) begin
                shadow[a] = (shadow_word(a) & ~byte_mask(be)) | lane;
            end
            if (!nc) begin
                touched[a[31:3]] = 1'b1;
            end
            #DRV;
            proc_ren = 1'b0;
            proc_wen = 1'b0;
        end
    endtask

    // final flush leaves memory holding every written word
    task automatic flush_and_verify();
        int n;
        pulse_flush();
        n = 0;
        while (!flush_done && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (!flush_done) begin
            $display("timeout waiting for flush_done after the final flush");
            errors++;
        end else begin
            @(posedge CLK);
            #DRV;
            foreach (shadow[k]) begin
                compare_hex($sformatf("mem data at %h", k), u_mem.peek_word(k), shadow[k]);
            end
            foreach (shadow[k]) begin
                if (!hung) begin
                    access(1'b0, k, '0, 4'hF);   // first touch of each block refetches
                end
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        int          n;
        void'($urandom(seed));
        nRST         = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        flush        = 1'b0;
        repeat (9) @(posedge CLK);
        @(negedge CLK);
        checks++;
        if (!proc_busy || mem_ren || mem_wen || flush_done) begin
            $display("cache outputs not idle while in reset");
            errors++;
        end
        @(posedge CLK);
        #DRV;
        nRST = 1'b1;

        // clear sweep keeps busy high and ends with one flush_done
        n = 0;
        while (!flush_done && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
            if (!proc_busy) begin
                $display("proc_busy dropped during the reset clear");
                errors++;
            end
        end
        if (!flush_done) begin
            $display("timeout waiting for flush_done after reset");
            errors++;
        end else begin
            compare_hex("flush_done cycle", n, N_SETS);
            @(negedge CLK);
            compare_hex("flush_done", flush_done, 0);
            @(posedge CLK);
            #DRV;
            access(1'b0, pick_addr(), '0, 4'hF);

            for (int i = 0; i < N_OPS && !hung; i++) begin
                if ($urandom % 40 == 0) begin
                    pulse_flush();
                end
                if ($urandom % 8 == 0) begin
                    a = NC_START + 32'(4 * ($urandom % 4));
                end else begin
                    a = pick_addr();
                end
                access(1'($urandom % 2), a, $urandom, 4'($urandom % 16));
            end

            if (!hung) begin
                flush_and_verify();
            end
        end
        end_run();
    end

endmodule

//--- l1_cache.f
l1_cache_pkg.sv
cache_data_array.sv
cache_lookup.sv
cache_sweep.sv
cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

//--- Bender.yml
package:
  name: l1_cache

sources:
  # design, package first
  - l1_cache_pkg.sv
  - cache_data_array.sv
  - cache_lookup.sv
  - cache_sweep.sv
  - cache_ctrl.sv
  - l1_cache.sv
  # simulation only
  - target: test
    files:
      - tb_mem_model.sv
      - tb_l1_cache.sv
